/* bench/conv_tb.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_tb import conv_pkg::*; ();

	localparam int MAX_PIX = 64;
	localparam int TIMEOUT = 5000; // cycles per wait

	logic                    clk;
	logic                    arst_n;
	logic                    start;
	conv_mode_e              mode;
	logic [`CONV_SIDE_W-1:0] side;
	logic [`CONV_ADDR_W-1:0] src_base;
	logic [`CONV_ADDR_W-1:0] dst_base;
	logic [`CONV_ADDR_W-1:0] wgt_base;
	logic                    mem_re;
	logic                    mem_we;
	logic [`CONV_ADDR_W-1:0] mem_addr;
	mem_word_u               mem_wdata;
	mem_word_u               mem_rdata;
	logic                    done;

	int          img [0:MAX_PIX-1]; // input map, row-major
	int          kern [0:`CONV_TAPS-1];
	logic [31:0] rng;

	conv_top dut0 (
		.clk, .arst_n, .start, .mode, .side, .src_base, .dst_base, .wgt_base,
		.mem_re, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .done
	);

	tb_mem mem0 (
		.clk, .re(mem_re), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int rand_pix();
		logic [31:0] r;
		r = xorshift();
		return int'($signed(r[7:0]));
	endfunction

	// expected pixel: sum, arithmetic shift, saturate, relu in pointwise
	function automatic int ref_pix(int r, int c, int n, bit pw);
		int sum;
		int k;
		int nr;
		int nc;
		int q;
		sum = 0;
		if (pw) begin
			sum = img[r*n + c] * kern[0];
		end else begin
			for (k = 0; k < `CONV_TAPS; k++) begin
				nr = r + k / 3 - 1;
				nc = c + k % 3 - 1;
				if (nr >= 0 && nr < n && nc >= 0 && nc < n)
					sum += img[nr*n + nc] * kern[k]; // outside counts as zero
			end
		end
		q = sum >>> `CONV_FRAC;
		if (q > 127)
			q = 127;
		else if (q < -128)
			q = -128;
		if (pw && q < 0)
			q = 0;
		return q;
	endfunction

	function automatic int read_pix(int addr);
		mem_word_u w;
		w = mem0.mem[addr];
		return int'(w.pix.val);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			$display("error in %s: expected %0d, actual %0d", name, expected, actual);
			abort_run("mismatch, stopping");
		end
	endtask

	task automatic load_map(input int base, input int n);
		mem_word_u w;
		int i;
		for (i = 0; i < n*n; i++) begin
			w = mem0.mem[base + i]; // fill stays in the upper bits
			w.pix.val = pix_t'(img[i]);
			mem0.mem[base + i] = w;
		end
	endtask

	task automatic load_kernel(input int addr);
		mem_word_u w;
		int k;
		w = '0;
		for (k = 0; k < `CONV_TAPS; k++)
			w.taps[k] = pix_t'(kern[k]);
		mem0.mem[addr] = w;
	endtask

	task automatic wait_done(input string name);
		int n;
		n = 0;
		while (!done && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!done)
			abort_run($sformatf("timeout in %s, done never came", name));
	endtask

	task automatic run_conv(input string name, input conv_mode_e m, input int n,
		input int src, input int dst, input int wgt);
		mode     = m;
		side     = n[`CONV_SIDE_W-1:0];
		src_base = src[`CONV_ADDR_W-1:0];
		dst_base = dst[`CONV_ADDR_W-1:0];
		wgt_base = wgt[`CONV_ADDR_W-1:0];
		start    = 1'b1;
		@(negedge clk);
		start    = 1'b0;
		wait_done(name);
		check({name, " read idle"}, 0, int'(mem_re)); // port quiet after the run
		check({name, " write idle"}, 0, int'(mem_we));
		@(negedge clk);
		check({name, " done pulse"}, 0, int'(done)); // single cycle
	endtask

	task automatic check_area(input string name, input int dst, input int n, input bit pw);
		mem_word_u w;
		int r;
		int c;
		for (r = 0; r < n; r++) begin
			for (c = 0; c < n; c++) begin
				w = mem0.mem[dst + r*n + c];
				check($sformatf("%s (%0d,%0d)", name, r, c), ref_pix(r, c, n, pw),
					int'(w.pix.val));
				check($sformatf("%s upper bits (%0d,%0d)", name, r, c), 0,
					int'(|w.pix.unused));
			end
		end
	endtask

	task automatic padding_test();
		int i;
		for (i = 0; i < 16; i++)
			img[i] = 1;
		for (i = 0; i < `CONV_TAPS; i++)
			kern[i] = 1;
		load_map('h100, 4);
		load_kernel('h10);
		run_conv("padding ones", mode_dw, 4, 'h100, 'h400, 'h10);
		check_area("padding ones", 'h400, 4, 1'b0);
		for (i = 0; i < `CONV_TAPS; i++)
			kern[i] = 16; // one after the shift
		load_kernel('h11);
		run_conv("padding count", mode_dw, 4, 'h100, 'h440, 'h11);
		check_area("padding count", 'h440, 4, 1'b0);
		check("padding corner", 4, read_pix('h440));
		check("padding edge", 6, read_pix('h441));
		check("padding interior", 9, read_pix('h445));
	endtask

	task automatic saturation_test();
		int i;
		for (i = 0; i < 9; i++)
			img[i] = 100;
		for (i = 0; i < `CONV_TAPS; i++)
			kern[i] = 127;
		load_map('h180, 3);
		load_kernel('h12);
		run_conv("saturate high", mode_dw, 3, 'h180, 'h480, 'h12);
		check_area("saturate high", 'h480, 3, 1'b0);
		check("saturate high corner", 127, read_pix('h480));
		for (i = 0; i < `CONV_TAPS; i++)
			kern[i] = -128;
		load_kernel('h13);
		run_conv("saturate low", mode_dw, 3, 'h180, 'h4c0, 'h13);
		check_area("saturate low", 'h4c0, 3, 1'b0);
		check("saturate low corner", -128, read_pix('h4c0)); // no relu here
	endtask

	task automatic pointwise_test();
		int i;
		for (i = 0; i < 16; i++)
			img[i] = rand_pix();
		img[0] = -50;
		img[1] = 100; // doubles past the top
		img[2] = -128;
		img[3] = 20;
		for (i = 1; i < `CONV_TAPS; i++)
			kern[i] = rand_pix(); // ignored in pointwise
		kern[0] = 32;
		load_map('h200, 4);
		load_kernel('h14);
		run_conv("pointwise", mode_pw, 4, 'h200, 'h500, 'h14);
		check_area("pointwise", 'h500, 4, 1'b1);
		check("pointwise negative", 0, read_pix('h500));
		check("pointwise clamp", 127, read_pix('h501));
		check("pointwise double", 40, read_pix('h503));
	endtask

	task automatic random_map_test();
		int i;
		for (i = 0; i < 25; i++)
			img[i] = rand_pix();
		for (i = 0; i < `CONV_TAPS; i++)
			kern[i] = rand_pix();
		load_map('h280, 5);
		load_kernel('h15);
		run_conv("random 5x5", mode_dw, 5, 'h280, 'h540, 'h15);
		check_area("random 5x5", 'h540, 5, 1'b0);
	endtask

	task automatic back_to_back_test();
		int kern_a [0:`CONV_TAPS-1];
		int i;
		for (i = 0; i < 16; i++)
			img[i] = rand_pix();
		load_map('h300, 4);
		for (i = 0; i < `CONV_TAPS; i++)
			kern[i] = rand_pix();
		kern_a = kern;
		load_kernel('h20);
		for (i = 0; i < `CONV_TAPS; i++)
			kern[i] = rand_pix();
		load_kernel('h21); // both kernels sit in memory
		run_conv("back to back first", mode_dw, 4, 'h300, 'h580, 'h20);
		run_conv("back to back second", mode_dw, 4, 'h300, 'h5c0, 'h21);
		check_area("back to back second", 'h5c0, 4, 1'b0);
		kern = kern_a;
		check_area("back to back first area", 'h580, 4, 1'b0);
	endtask

	initial begin
		rng      = 32'd90355;
		arst_n   = 1'b0;
		start    = 1'b0;
		mode     = mode_dw;
		side     = '0;
		src_base = '0;
		dst_base = '0;
		wgt_base = '0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check("reset read", 0, int'(mem_re));
		check("reset write", 0, int'(mem_we));
		check("reset done", 0, int'(done));
		padding_test();
		saturation_test();
		pointwise_test();
		random_map_test();
		back_to_back_test();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_mem.sv */
`default_nettype none

`include "conv_consts.svh"

module tb_mem (
	input  wire logic                    clk,
	input  wire logic                    re,
	input  wire logic                    we,
	input  wire logic [`CONV_ADDR_W-1:0] addr,
	input  wire logic [`CONV_MEM_W-1:0]  wdata,
	output logic      [`CONV_MEM_W-1:0]  rdata
);

	localparam int DEPTH = 1 << `CONV_ADDR_W;

	logic [`CONV_MEM_W-1:0] mem [0:DEPTH-1];

	initial begin
		rdata = '0;
		// fill word tracks the full address, low byte mixes both halves
		for (int a = 0; a < DEPTH; a++)
			mem[a] = {{(`CONV_MEM_W-24){1'b0}}, 16'(a), 8'(a ^ (a >> 8))};
	end

	always @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		if (re)
			rdata <= mem[addr]; // one cycle read latency
	end

endmodule

`default_nettype wire

/* logic/conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// pixel and tap width
`define CONV_PIX_W 8

// taps in a 3x3 kernel
`define CONV_TAPS 9

// one memory word holds a whole kernel
`define CONV_MEM_W 72

`define CONV_ADDR_W 16

// map side count, up to 127
`define CONV_SIDE_W 7

`define CONV_ACC_W 20

// requantisation shift
`define CONV_FRAC 4

`endif

/* logic/conv_mac.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_mac import conv_pkg::*; #(
	parameter int TAP_IW = $clog2(`CONV_TAPS)
) (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire conv_mode_e              mode,
	input  wire mem_word_u               taps,
	input  wire mem_word_u               bus_rdata,
	input  wire logic                    pix_valid,
	input  wire logic                    zero_tap,
	input  wire logic [TAP_IW-1:0]       tap_idx,
	input  wire logic                    first_tap,
	input  wire logic                    last_tap,
	input  wire logic [`CONV_ADDR_W-1:0] out_idx,
	output logic                         res_valid,
	output pix_t                         res_pix,
	output logic      [`CONV_ADDR_W-1:0] res_idx
);

	localparam pix_t PIX_MAX = {1'b0, {(`CONV_PIX_W-1){1'b1}}};
	localparam pix_t PIX_MIN = {1'b1, {(`CONV_PIX_W-1){1'b0}}};

	pix_t                           pix;
	pix_t                           tap_w;
	logic signed [2*`CONV_PIX_W-1:0] prod;
	logic signed [`CONV_ACC_W-1:0]   acc;
	logic signed [`CONV_ACC_W-1:0]   sum;
	logic signed [`CONV_ACC_W-1:0]   shifted;
	pix_t                           sat;
	pix_t                           q;

	assign pix   = zero_tap ? '0 : bus_rdata.pix.val; // padding counts as zero
	assign tap_w = taps.taps[tap_idx];
	assign prod  = pix * tap_w;
	assign sum   = first_tap ? prod : acc + prod;

	assign shifted = sum >>> `CONV_FRAC;

	always_comb begin
		if (shifted > PIX_MAX)
			sat = PIX_MAX;
		else if (shifted < PIX_MIN)
			sat = PIX_MIN;
		else
			sat = shifted[`CONV_PIX_W-1:0];
		// relu in pointwise only
		q = ((mode == mode_pw) && (sat < 0)) ? '0 : sat;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			res_valid <= 1'b0;
		else
			res_valid <= pix_valid & last_tap;
	end

	always_ff @(posedge clk) begin
		if (pix_valid)
			acc <= sum;
		if (pix_valid && last_tap) begin
			res_pix <= q;
			res_idx <= out_idx;
		end
	end

endmodule

`default_nettype wire

/* logic/conv_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_pkg;

	// signed pixel, also used for one kernel tap
	typedef logic signed [`CONV_PIX_W-1:0] pix_t;

	typedef struct packed {
		logic [`CONV_MEM_W-`CONV_PIX_W-1:0] unused; // upper bits, zero on write
		pix_t                               val;    // pixel in the low byte
	} pix_word_s;

	// one memory word, either a full kernel or a single pixel
	typedef union packed {
		pix_t [`CONV_TAPS-1:0] taps; // tap 0 is top-left, row-major
		pix_word_s             pix;
	} mem_word_u;

	typedef enum logic {
		mode_dw = 1'b0, // 3x3 depthwise
		mode_pw = 1'b1  // 1x1 pointwise with relu
	} conv_mode_e;

endpackage

`default_nettype wire

/* logic/conv_top.sv */
`default_nettype none

`include "conv_consts.svh"

module conv_top import conv_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic                    start,
	input  wire conv_mode_e              mode,
	input  wire logic [`CONV_SIDE_W-1:0] side,
	input  wire logic [`CONV_ADDR_W-1:0] src_base,
	input  wire logic [`CONV_ADDR_W-1:0] dst_base,
	input  wire logic [`CONV_ADDR_W-1:0] wgt_base,
	output logic                         mem_re,
	output logic                         mem_we,
	output logic      [`CONV_ADDR_W-1:0] mem_addr,
	output mem_word_u                    mem_wdata,
	input  wire mem_word_u               mem_rdata,
	output logic                         done
);

	localparam int TAP_IW = $clog2(`CONV_TAPS);

	mem_word_u               taps;
	logic                    taps_ready;
	logic                    busy;
	logic [TAP_IW-1:0]       tap_idx;
	logic                    first_tap;
	logic                    last_tap;
	logic                    zero_tap;
	logic                    pix_valid;
	logic [`CONV_ADDR_W-1:0] out_idx;
	logic                    run_end;
	logic                    res_valid;
	pix_t                    res_pix;
	logic [`CONV_ADDR_W-1:0] res_idx;

	mem_bus_if wr_bus ();
	mem_bus_if kl_bus ();
	mem_bus_if wf_bus ();

	mem_arbiter u_arb (
		.clk, .arst_n,
		.wr_bus, .kl_bus, .wf_bus,
		.mem_re, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
	);

	kernel_loader u_kl (
		.clk, .arst_n, .start, .wgt_base,
		.bus(kl_bus),
		.taps, .taps_ready
	);

	window_fetcher #(.TAP_IW(TAP_IW)) u_wf (
		.clk, .arst_n, .start, .mode, .side, .src_base, .taps_ready, .busy,
		.bus(wf_bus),
		.tap_idx, .first_tap, .last_tap, .zero_tap, .pix_valid, .out_idx, .run_end
	);

	conv_mac #(.TAP_IW(TAP_IW)) u_mac (
		.clk, .arst_n, .mode, .taps,
		.bus_rdata(wf_bus.rdata), // pixels come back on the fetcher's bus
		.pix_valid, .zero_tap, .tap_idx, .first_tap, .last_tap, .out_idx,
		.res_valid, .res_pix, .res_idx
	);

	result_writer u_wr (
		.clk, .arst_n, .dst_base, .res_valid, .res_pix, .res_idx, .run_end,
		.bus(wr_bus),
		.busy, .done
	);

endmodule

`default_nettype wire

/* logic/kernel_loader.sv */
`default_nettype none

`include "conv_consts.svh"

module kernel_loader import conv_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic                    start,
	input  wire logic [`CONV_ADDR_W-1:0] wgt_base,
	mem_bus_if.client                    bus,
	output mem_word_u                    taps,
	output logic                         taps_ready
);

	logic                    req_q;  // read pending grant
	logic                    wait_q; // granted, data due next cycle
	logic [`CONV_ADDR_W-1:0] addr_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_q      <= 1'b0;
			wait_q     <= 1'b0;
			taps_ready <= 1'b0;
		end else if (start) begin
			req_q      <= 1'b1;
			wait_q     <= 1'b0;
			taps_ready <= 1'b0; // old kernel no longer valid
		end else if (req_q && bus.gnt) begin
			req_q  <= 1'b0;
			wait_q <= 1'b1;
		end else if (wait_q && bus.rvalid) begin
			wait_q     <= 1'b0;
			taps_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			addr_q <= wgt_base;
		if (wait_q && bus.rvalid)
			taps <= bus.rdata; // whole word, nine taps
	end

	assign bus.req   = req_q;
	assign bus.we    = 1'b0;
	assign bus.addr  = addr_q;
	assign bus.wdata = '0;

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`default_nettype none

`include "conv_consts.svh"

module mem_arbiter import conv_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	mem_bus_if.arbiter                   wr_bus,
	mem_bus_if.arbiter                   kl_bus,
	mem_bus_if.arbiter                   wf_bus,
	output logic                         mem_re,
	output logic                         mem_we,
	output logic     [`CONV_ADDR_W-1:0]  mem_addr,
	output mem_word_u                    mem_wdata,
	input  wire mem_word_u               mem_rdata
);

	logic wr_sel;
	logic kl_sel;
	logic wf_sel;
	logic rd_wr; // owner of the read in flight
	logic rd_kl;
	logic rd_wf;

	// fixed priority: writer, loader, fetcher
	assign wr_sel = wr_bus.req;
	assign kl_sel = kl_bus.req & ~wr_bus.req;
	assign wf_sel = wf_bus.req & ~wr_bus.req & ~kl_bus.req;

	assign wr_bus.gnt = wr_sel;
	assign kl_bus.gnt = kl_sel;
	assign wf_bus.gnt = wf_sel;

	always_comb begin
		mem_we    = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		if (wr_sel) begin
			mem_we    = wr_bus.we;
			mem_addr  = wr_bus.addr;
			mem_wdata = wr_bus.wdata;
		end else if (kl_sel) begin
			mem_we    = kl_bus.we;
			mem_addr  = kl_bus.addr;
			mem_wdata = kl_bus.wdata;
		end else if (wf_sel) begin
			mem_we    = wf_bus.we;
			mem_addr  = wf_bus.addr;
			mem_wdata = wf_bus.wdata;
		end
	end

	assign mem_re = (wr_sel | kl_sel | wf_sel) & ~mem_we;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_wr <= 1'b0;
			rd_kl <= 1'b0;
			rd_wf <= 1'b0;
		end else begin
			rd_wr <= wr_sel & ~wr_bus.we;
			rd_kl <= kl_sel & ~kl_bus.we;
			rd_wf <= wf_sel & ~wf_bus.we;
		end
	end

	// return data only to the client that issued the read
	assign wr_bus.rvalid = rd_wr;
	assign kl_bus.rvalid = rd_kl;
	assign wf_bus.rvalid = rd_wf;
	assign wr_bus.rdata  = rd_wr ? mem_rdata : '0;
	assign kl_bus.rdata  = rd_kl ? mem_rdata : '0;
	assign wf_bus.rdata  = rd_wf ? mem_rdata : '0;

endmodule

`default_nettype wire

/* logic/mem_bus_if.sv */
`default_nettype none

`include "conv_consts.svh"

interface mem_bus_if import conv_pkg::*; ();

	logic                    req;    // held until gnt
	logic                    we;
	logic [`CONV_ADDR_W-1:0] addr;
	mem_word_u               wdata;
	logic                    gnt;    // access happens this cycle
	mem_word_u               rdata;
	logic                    rvalid; // one cycle after a read grant

	modport client (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

`default_nettype wire

/* logic/result_writer.sv */
`default_nettype none

`include "conv_consts.svh"

module result_writer import conv_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic [`CONV_ADDR_W-1:0] dst_base,
	input  wire logic                    res_valid,
	input  wire pix_t                    res_pix,
	input  wire logic [`CONV_ADDR_W-1:0] res_idx,
	input  wire logic                    run_end,
	mem_bus_if.client                    bus,
	output logic                         busy,
	output logic                         done
);

	logic                    held;
	logic                    end_pend; // last result of the run is held
	pix_t                    pix_q;
	logic [`CONV_ADDR_W-1:0] addr_q;
	mem_word_u               wr_word;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held     <= 1'b0;
			end_pend <= 1'b0;
			done     <= 1'b0;
		end else begin
			if (res_valid)
				held <= 1'b1;
			else if (bus.gnt)
				held <= 1'b0;
			if (run_end)
				end_pend <= 1'b1;
			else if (bus.gnt)
				end_pend <= 1'b0;
			done <= end_pend & bus.gnt; // one cycle after the final grant
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid) begin
			pix_q  <= res_pix;
			addr_q <= dst_base + res_idx;
		end
	end

	always_comb begin
		wr_word         = '0;
		wr_word.pix.val = pix_q;
	end

	assign bus.req   = held;
	assign bus.we    = 1'b1;
	assign bus.addr  = addr_q;
	assign bus.wdata = wr_word;
	assign busy      = held;

endmodule

`default_nettype wire

/* logic/window_fetcher.sv */
`default_nettype none

`include "conv_consts.svh"

module window_fetcher import conv_pkg::*; #(
	parameter int TAP_IW = $clog2(`CONV_TAPS)
) (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic                    start,
	input  wire conv_mode_e              mode,
	input  wire logic [`CONV_SIDE_W-1:0] side,
	input  wire logic [`CONV_ADDR_W-1:0] src_base,
	input  wire logic                    taps_ready,
	input  wire logic                    busy,
	mem_bus_if.client                    bus,
	output logic      [TAP_IW-1:0]       tap_idx,
	output logic                         first_tap,
	output logic                         last_tap,
	output logic                         zero_tap,
	output logic                         pix_valid,
	output logic      [`CONV_ADDR_W-1:0] out_idx,
	output logic                         run_end
);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_KWAIT = 2'd1; // kernel load
	localparam logic [1:0] S_OUT   = 2'd2; // next output, waits on writer
	localparam logic [1:0] S_TAP   = 2'd3;

	logic [1:0]                     state;
	logic [`CONV_SIDE_W-1:0]        row;
	logic [`CONV_SIDE_W-1:0]        col;
	logic [1:0]                     tr; // window row
	logic [1:0]                     tc; // window column
	logic [TAP_IW-1:0]              tap;
	logic [`CONV_ADDR_W-1:0]        idx;
	logic [1:0]                     off_r;
	logic [1:0]                     off_c;
	logic signed [`CONV_SIDE_W+1:0] nr; // neighbour row, may be -1 or side
	logic signed [`CONV_SIDE_W+1:0] nc;
	logic                           in_map;
	logic                           last_in_win;
	logic                           last_out;
	logic                           accept;
	logic                           zero_q;
	logic                           first_q;
	logic                           last_q;
	logic                           end_q;

	// pointwise uses the centre pixel only
	assign off_r = (mode == mode_pw) ? 2'd1 : tr;
	assign off_c = (mode == mode_pw) ? 2'd1 : tc;
	assign nr    = $signed({2'b00, row}) + $signed({1'b0, off_r}) - 1;
	assign nc    = $signed({2'b00, col}) + $signed({1'b0, off_c}) - 1;

	assign in_map = (nr >= 0) && (nr < $signed({2'b00, side})) &&
		(nc >= 0) && (nc < $signed({2'b00, side}));

	assign last_in_win = (mode == mode_pw) || (tap == `CONV_TAPS - 1);
	assign last_out    = (row == side - 1'b1) && (col == side - 1'b1);

	// padding taps need no memory access
	assign accept = (state == S_TAP) && (!in_map || bus.gnt);

	assign bus.req   = (state == S_TAP) && in_map;
	assign bus.we    = 1'b0;
	assign bus.addr  = src_base + nr[`CONV_SIDE_W-1:0] * side + nc[`CONV_SIDE_W-1:0];
	assign bus.wdata = '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= S_IDLE;
			row     <= '0;
			col     <= '0;
			tr      <= '0;
			tc      <= '0;
			tap     <= '0;
			idx     <= '0;
			zero_q  <= 1'b0;
			first_q <= 1'b0;
			last_q  <= 1'b0;
			end_q   <= 1'b0;
			run_end <= 1'b0;
		end else begin
			// tags line up with the pixel one cycle after accept
			zero_q  <= accept && !in_map;
			first_q <= accept && (tap == '0);
			last_q  <= accept && last_in_win;
			end_q   <= accept && last_in_win && last_out;
			run_end <= end_q; // same cycle as the final res_valid
			case (state)
				S_IDLE: begin
					if (start) begin
						row   <= '0;
						col   <= '0;
						idx   <= '0;
						state <= S_KWAIT;
					end
				end
				S_KWAIT: begin
					if (taps_ready)
						state <= S_OUT;
				end
				S_OUT: begin
					if (!busy) begin
						tr    <= '0;
						tc    <= '0;
						tap   <= '0;
						state <= S_TAP;
					end
				end
				default: begin
					if (accept && last_in_win) begin
						idx <= idx + 1'b1;
						if (last_out) begin
							state <= S_IDLE;
						end else begin
							state <= S_OUT;
							if (col == side - 1'b1) begin
								col <= '0;
								row <= row + 1'b1;
							end else begin
								col <= col + 1'b1;
							end
						end
					end else if (accept) begin
						tap <= tap + 1'b1;
						if (tc == 2'd2) begin
							tc <= '0;
							tr <= tr + 1'b1;
						end else begin
							tc <= tc + 1'b1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			tap_idx <= tap;
			out_idx <= idx;
		end
	end

	assign zero_tap  = zero_q;
	assign first_tap = first_q;
	assign last_tap  = last_q;
	assign pix_valid = zero_q | bus.rvalid;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the convolution engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module conv_tb \
	-Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/Vconv_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0

/* verilog.f */
+incdir+logic
logic/conv_pkg.sv
logic/mem_bus_if.sv
logic/mem_arbiter.sv
logic/kernel_loader.sv
logic/window_fetcher.sv
logic/conv_mac.sv
logic/result_writer.sv
logic/conv_top.sv
bench/tb_mem.sv
bench/conv_tb.sv
